// File: verilog/sprite_pkg.sv
////////////////////////////////////////////////////////////
// sprite subsystem package
// test screen geometry, sprite size, scale and colour types
////////////////////////////////////////////////////////////

`default_nettype none

package sprite_pkg;

    // screen coordinates
    localparam int CORDW    = 6;
    typedef logic [CORDW-1:0] coord_t;

    // reduced test geometry, no sync pulses
    localparam int H_ACTIVE = 40;  // visible pixels per line
    localparam int H_TOTAL  = 50;  // incl horizontal blanking
    localparam int V_ACTIVE = 30;  // visible lines per frame
    localparam int V_TOTAL  = 32;

    // sprite graphic, one word per graphic line
    localparam int SPR_W    = 8;
    localparam int SPR_H    = 8;
    localparam int SCALE_X  = 2;
    localparam int SCALE_Y  = 2;
    localparam int SPR_LSB  = 0;   // left-most pixel sits in the msb

    localparam int ADDRW    = 3;   // enough for SPR_H lines
    typedef logic [SPR_W-1:0] gfx_line_t;
    typedef logic [ADDRW-1:0] gfx_addr_t;

    typedef logic [3:0] colour_t;  // 4-bit colour, 0 is black

endpackage

`default_nettype wire

// File: verilog/scan_timing.sv
////////////////////////////////////////////////////////////
// scan timing: screen position counters, active area and
// blanking flags, sprite start strobe
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module scan_timing import sprite_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire coord_t spry,    // sprite top line
    output coord_t      sx,      // horizontal position
    output coord_t      sy,      // vertical position
    output logic        de,      // inside active area
    output logic        hblank,  // horizontal blanking
    output logic        start    // one line above the sprite
);

    logic line_end;   // last pixel of a line
    logic frame_end;  // last line of a frame

    assign line_end  = (sx == coord_t'(H_TOTAL - 1));
    assign frame_end = (sy == coord_t'(V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            sy <= frame_end ? '0 : sy + 1'b1;  // step line on wrap
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // flags straight off the counters, no added latency
    assign de     = (sx < coord_t'(H_ACTIVE)) && (sy < coord_t'(V_ACTIVE));
    assign hblank = (sx >= coord_t'(H_ACTIVE));

    // strobe at start of the line before the sprite, so the engine
    // can fetch its first graphic line in that line's blanking
    assign start  = (sx == '0) && (sy == coord_t'(spry - 1'b1));

    // counter never leaves the line
    a_sx_range: assert property (@(posedge clk) disable iff (rst)
        sx < coord_t'(H_TOTAL))
        else $error("sx out of range");

endmodule

`default_nettype wire

// File: verilog/sprite_rom.sv
////////////////////////////////////////////////////////////
// sprite graphic memory, one bit per pixel
// write port for the environment, one-cycle read
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module sprite_rom import sprite_pkg::*; (
    input  wire logic      clk,
    input  wire logic      we,     // write enable
    input  wire gfx_addr_t waddr,  // line to write
    input  wire gfx_line_t wdata,  // graphic line in
    input  wire gfx_addr_t raddr,  // line to read
    output gfx_line_t      rdata   // valid one clock after raddr
);

    // one word per graphic line
    // contents unknown until loaded
    gfx_line_t mem [SPR_H];

    // loaded by the environment, normally during reset
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, engine counts on exactly one cycle
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: verilog/sprite.sv
////////////////////////////////////////////////////////////
// sprite engine fetching one 1bpp line per screen line in
// blanking and drawing it scaled at the sprite position
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module sprite import sprite_pkg::*; #(
    parameter int LSB     = SPR_LSB,  // 1 when first pixel is the lsb
    parameter int SCALE_X = sprite_pkg::SCALE_X,
    parameter int SCALE_Y = sprite_pkg::SCALE_Y
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      start,      // begin a new sprite
    input  wire logic      dma_avail,  // memory free during blanking
    input  wire coord_t    sx,         // current screen x
    input  wire coord_t    sprx,       // sprite left edge
    input  wire gfx_line_t gfx_data,   // line from graphic memory
    output gfx_addr_t      gfx_addr,   // graphic line address
    output logic           pix,        // pixel to draw
    output logic           done        // whole sprite drawn
);

    // counter widths kept at 1 bit min for scale of 1
    localparam int OXW = (SPR_W > 1) ? $clog2(SPR_W) : 1;
    localparam int OYW = (SPR_H > 1) ? $clog2(SPR_H) : 1;
    localparam int CXW = (SCALE_X > 1) ? $clog2(SCALE_X) : 1;
    localparam int CYW = (SCALE_Y > 1) ? $clog2(SCALE_Y) : 1;

    typedef enum logic [2:0] {
        IDLE,       // wait for start
        START,      // reset line position
        AWAIT_DMA,  // wait for memory access
        READ_MEM,   // latch graphic line
        AWAIT_POS,  // wait for sprx
        DRAW,       // one pixel per clock
        NEXT_LINE,  // step vertical scale
        DONE        // flag completion
    } state_t;

    state_t state, state_next;

    logic [OXW-1:0] ox;     // pixel within graphic line
    logic [OYW-1:0] oy;     // graphic line
    logic [CXW-1:0] cnt_x;  // horizontal repeat
    logic [CYW-1:0] cnt_y;  // vertical repeat

    gfx_line_t spr_line;    // local copy with first pixel at bit 0
    gfx_line_t gfx_ord;     // memory word in drawing order

    logic line_complete;    // last clock of a screen line
    logic line_gfx_complete;
    logic draw_complete;

    // put left-most pixel at bit 0
    always_comb begin
        for (int i = 0; i < SPR_W; i++) begin
            gfx_ord[i] = (LSB != 0) ? gfx_data[i] : gfx_data[SPR_W-1-i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            ox       <= '0;
            oy       <= '0;
            cnt_x    <= '0;
            cnt_y    <= '0;
            gfx_addr <= '0;  // base address
            done     <= 1'b0;
        end else begin
            state <= state_next;
            case (state)
                START: begin
                    done     <= 1'b0;
                    oy       <= '0;
                    cnt_y    <= '0;
                    gfx_addr <= '0;
                end
                AWAIT_POS: begin  // rewind for each screen line
                    ox    <= '0;
                    cnt_x <= '0;
                end
                DRAW: begin
                    if (cnt_x == CXW'(SCALE_X - 1)) begin
                        ox    <= ox + 1'b1;
                        cnt_x <= '0;
                    end else begin
                        cnt_x <= cnt_x + 1'b1;
                    end
                end
                NEXT_LINE: begin
                    if (line_gfx_complete) begin  // new graphic line
                        oy       <= oy + 1'b1;
                        cnt_y    <= '0;
                        gfx_addr <= gfx_addr + 1'b1;
                    end else begin
                        cnt_y <= cnt_y + 1'b1;
                    end
                end
                DONE: done <= 1'b1;  // held until next start
                default: ;
            endcase
        end
    end

    // read data is valid here since gfx_addr settled a cycle earlier
    always_ff @(posedge clk) begin
        if (state == READ_MEM) begin
            spr_line <= gfx_ord;
        end
    end

    assign line_complete     = (ox == OXW'(SPR_W - 1)) && (cnt_x == CXW'(SCALE_X - 1));
    assign line_gfx_complete = (cnt_y == CYW'(SCALE_Y - 1));
    assign draw_complete     = (oy == OYW'(SPR_H - 1)) && line_complete && line_gfx_complete;

    always_comb begin
        pix        = 1'b0;
        state_next = state;
        case (state)
            IDLE:      state_next = start ? START : IDLE;
            START:     state_next = AWAIT_DMA;
            AWAIT_DMA: state_next = dma_avail ? READ_MEM : AWAIT_DMA;
            READ_MEM:  state_next = AWAIT_POS;
            AWAIT_POS: state_next = (sx == sprx) ? DRAW : AWAIT_POS;  // draws from sprx+1
            DRAW: begin
                pix        = spr_line[ox];
                state_next = draw_complete ? DONE :
                             line_complete ? NEXT_LINE : DRAW;
            end
            NEXT_LINE: state_next = line_gfx_complete ? AWAIT_DMA : AWAIT_POS;
            DONE:      state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    // address never steps past the last graphic line
    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        (state == NEXT_LINE && line_gfx_complete) |-> (int'(gfx_addr) < SPR_H - 1))
        else $error("gfx_addr beyond graphic");

    // pixels land only inside the sprite's horizontal span
    a_pix_span: assert property (@(posedge clk) disable iff (rst)
        pix |-> (int'(sx) > int'(sprx)) && (int'(sx) - int'(sprx) <= SPR_W * SCALE_X))
        else $error("pix set outside sprite span");

endmodule

`default_nettype wire

// File: verilog/pixel_output.sv
////////////////////////////////////////////////////////////
// pixel output stage picking fg or bg colour per pixel and
// registering it with display enable and screen coordinates
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module pixel_output import sprite_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    pix,     // sprite pixel set
    input  wire logic    de,      // active area
    input  wire coord_t  sx,
    input  wire coord_t  sy,
    input  wire colour_t fg,      // sprite colour
    input  wire colour_t bg,      // background colour
    output colour_t      colour,
    output logic         de_out,  // doubles as valid marker
    output coord_t       sx_out,  // position of colour
    output coord_t       sy_out
);

    colour_t colour_sel;

    // black in blanking else sprite over background
    assign colour_sel = !de ? '0 : (pix ? fg : bg);

    always_ff @(posedge clk) begin
        if (rst) begin
            colour <= '0;
            de_out <= 1'b0;
            sx_out <= '0;
            sy_out <= '0;
        end else begin
            colour <= colour_sel;
            de_out <= de;
            sx_out <= sx;  // coordinates follow the colour
            sy_out <= sy;
        end
    end

    // engine never draws into blanking
    a_pix_active: assert property (@(posedge clk) disable iff (rst)
        pix |-> de)
        else $error("sprite pixel outside active area");

endmodule

`default_nettype wire

// File: verilog/sprite_top.sv
////////////////////////////////////////////////////////////
// sprite subsystem top: scan timing, sprite engine with its
// graphic memory, pixel output
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module sprite_top import sprite_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire coord_t    sprx,       // sprite position, held steady
    input  wire coord_t    spry,
    input  wire colour_t   fg,
    input  wire colour_t   bg,
    input  wire logic      rom_we,     // graphic load port
    input  wire gfx_addr_t rom_waddr,
    input  wire gfx_line_t rom_wdata,
    output colour_t        colour,     // one clock behind scan
    output logic           de_out,
    output coord_t         sx_out,
    output coord_t         sy_out
);

    coord_t    sx;
    coord_t    sy;
    logic      de;
    logic      hblank;
    logic      start;
    gfx_addr_t gfx_addr;
    gfx_line_t gfx_data;
    logic      pix;

    scan_timing timing (
        .clk    (clk),
        .rst    (rst),
        .spry   (spry),
        .sx     (sx),
        .sy     (sy),
        .de     (de),
        .hblank (hblank),
        .start  (start)
    );

    sprite_rom rom (
        .clk   (clk),
        .we    (rom_we),
        .waddr (rom_waddr),
        .wdata (rom_wdata),
        .raddr (gfx_addr),
        .rdata (gfx_data)
    );

    // memory access only in horizontal blanking
    sprite #(
        .LSB     (SPR_LSB),
        .SCALE_X (SCALE_X),
        .SCALE_Y (SCALE_Y)
    ) engine (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .dma_avail (hblank),
        .sx        (sx),
        .sprx      (sprx),
        .gfx_data  (gfx_data),
        .gfx_addr  (gfx_addr),
        .pix       (pix),
        .done      ()
    );

    pixel_output out_stage (
        .clk    (clk),
        .rst    (rst),
        .pix    (pix),
        .de     (de),
        .sx     (sx),
        .sy     (sy),
        .fg     (fg),
        .bg     (bg),
        .colour (colour),
        .de_out (de_out),
        .sx_out (sx_out),
        .sy_out (sy_out)
    );

endmodule

`default_nettype wire

// File: tb/tb_sprite.sv
////////////////////////////////////////////////////////////
// testbench for the sprite subsystem with random graphics at
// three positions and every output pixel against a reference
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_sprite import sprite_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;           // one graphic line written per cycle
    localparam int FRAME        = H_TOTAL * V_TOTAL;
    localparam int X_MAX        = H_ACTIVE - 1 - SPR_W * SCALE_X;  // right limit for sprx
    localparam int Y_MAX        = V_ACTIVE - SPR_H * SCALE_Y;      // bottom limit for spry
    localparam int WATCHDOG_NS  = 2 * 4 * 3 * FRAME * CLK_PERIOD;  // 4 frames x 3 tests doubled

    logic      clk = 1'b0;
    logic      rst;
    coord_t    sprx, spry;
    colour_t   fg, bg;
    logic      rom_we;
    gfx_addr_t rom_waddr;
    gfx_line_t rom_wdata;
    colour_t   colour;
    logic      de_out;
    coord_t    sx_out, sy_out;

    gfx_line_t gfx [SPR_H];  // copy of what went into the rom

    // screen position model and values seen at each edge
    int      scan_x = 0, scan_y = 0;
    int      out_x = 0, out_y = 0;
    logic    live = 1'b0;   // rst was low at last edge
    logic    armed = 1'b0;  // at least one edge has passed
    colour_t fg_q, bg_q;

    int colour_errs = 0;
    int de_errs     = 0;
    int coord_errs  = 0;
    int checks      = 0;

    sprite_top dut (
        .clk       (clk),
        .rst       (rst),
        .sprx      (sprx),
        .spry      (spry),
        .fg        (fg),
        .bg        (bg),
        .rom_we    (rom_we),
        .rom_waddr (rom_waddr),
        .rom_wdata (rom_wdata),
        .colour    (colour),
        .de_out    (de_out),
        .sx_out    (sx_out),
        .sy_out    (sy_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // expected colour at screen (x, y) straight from the drawing rules
    function automatic colour_t expected_colour(input int x, input int y,
                                                input colour_t f, input colour_t b);
        int gx;
        int gy;
        gx = x - int'(sprx) - 1;  // sprite starts one pixel right of sprx
        gy = y - int'(spry);
        if (x >= H_ACTIVE || y >= V_ACTIVE) return '0;  // blanking is black
        if (gx >= 0 && gx < SPR_W * SCALE_X && gy >= 0 && gy < SPR_H * SCALE_Y)
            return gfx[gy / SCALE_Y][SPR_W - 1 - gx / SCALE_X] ? f : b;  // msb first
        return b;
    endfunction

    task automatic check_colour(input colour_t got, input colour_t exp, input string what);
        if (got !== exp) begin
            colour_errs++;
            $display("ERROR %0t ns: %s colour %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_de(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            de_errs++;
            $display("ERROR %0t ns: %s de_out %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_coord(input coord_t got, input coord_t exp, input string what);
        if (got !== exp) begin
            coord_errs++;
            $display("ERROR %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // nonzero fg and bg that never match
    task automatic pick_colours();
        fg = colour_t'(1 + $urandom % 15);
        bg = colour_t'(1 + (int'(fg) + $urandom % 14) % 15);
    endtask

    // hold reset while loading a fresh random graphic
    task automatic load_and_reset(input coord_t x, input coord_t y);
        gfx_line_t line;
        rst  = 1'b1;
        sprx = x;
        spry = y;
        pick_colours();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            line = gfx_line_t'($urandom);
            if (i < SPR_H) gfx[i] = line;
            rom_we    = (i < SPR_H);
            rom_waddr = gfx_addr_t'(i);
            rom_wdata = line;
            @(posedge clk);
            #2;
        end
        rom_we = 1'b0;
        rst    = 1'b0;
        $display("sprite at (%0d, %0d), fg %h bg %h", sprx, spry, fg, bg);
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // the output registered at this edge shows the position held before it
    always @(posedge clk) begin
        armed <= 1'b1;
        live  <= !rst;
        fg_q  <= fg;
        bg_q  <= bg;
        out_x <= scan_x;
        out_y <= scan_y;
        if (rst) begin
            scan_x <= 0;
            scan_y <= 0;
        end else if (scan_x == H_TOTAL - 1) begin
            scan_x <= 0;
            scan_y <= (scan_y == V_TOTAL - 1) ? 0 : scan_y + 1;
        end else begin
            scan_x <= scan_x + 1;
        end
    end

    // outputs are settled mid-cycle
    always @(negedge clk) begin
        if (armed && !live) begin  // registered under reset
            check_de(de_out, 1'b0, "reset");
            check_colour(colour, '0, "reset");
        end else if (armed && !rst) begin  // cycle entering reset is skipped
            check_coord(sx_out, coord_t'(out_x), "sx_out");
            check_coord(sy_out, coord_t'(out_y), "sy_out");
            check_de(de_out, (out_x < H_ACTIVE) && (out_y < V_ACTIVE), "active");
            check_colour(colour, expected_colour(out_x, out_y, fg_q, bg_q), "pixel");
            checks++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'haf82));
        rst       = 1'b1;
        sprx      = '0;
        spry      = '0;
        fg        = '0;
        bg        = '0;
        rom_we    = 1'b0;
        rom_waddr = '0;
        rom_wdata = '0;

        // random position with colours swapped around line 16 of frame two
        load_and_reset(coord_t'(1 + $urandom % X_MAX), coord_t'(1 + $urandom % Y_MAX));
        run_cycles(3 * FRAME / 2);
        {fg, bg} = {bg, fg};
        run_cycles(FRAME / 2);

        load_and_reset(coord_t'(1), coord_t'(1));  // upper-left limit
        run_cycles(2 * FRAME);

        load_and_reset(coord_t'(X_MAX), coord_t'(Y_MAX));  // lower-right limit
        run_cycles(2 * FRAME);

        @(negedge clk);
        #1;
        $display("checks %0d, colour errors %0d, de errors %0d, coordinate errors %0d",
                 checks, colour_errs, de_errs, coord_errs);
        if (colour_errs == 0 && de_errs == 0 && coord_errs == 0 && checks > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
verilog/sprite_pkg.sv
verilog/scan_timing.sv
verilog/sprite_rom.sv
verilog/sprite.sv
verilog/pixel_output.sv
verilog/sprite_top.sv
tb/tb_sprite.sv

// File: Makefile
# Verilator build and run for the sprite subsystem testbench

TOP := tb_sprite

.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

build:
	verilator --binary -Wno-fatal -f tb.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only -Wall verilog/sprite_pkg.sv verilog/scan_timing.sv \
		verilog/sprite_rom.sv verilog/sprite.sv verilog/pixel_output.sv \
		verilog/sprite_top.sv --top-module sprite_top

clean:
	rm -rf obj_dir
